//--- Bender.yml
package:
  name: freelist_checkpoint

sources:
  - include_dirs:
      - hw
    files:
      - hw/ckpt_pkg.sv
      - hw/ckpt_bank.sv
      - hw/ckpt_alloc_ctrl.sv
      - hw/ckpt_release_arbiter.sv
      - hw/freelist_checkpoint.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/freelist_checkpoint_tb.sv

//--- hw/ckpt_alloc_ctrl.sv
// Bank selection for acquired PRFs and per-bank commit/abandon decode
// Assumes an FGR is held by at most one active bank at a time
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_alloc_ctrl (
    // Acquire request
    input  logic                   i_acquire_valid,
    input  ckpt_pkg::acquire_t     i_acquire,

    // Group resolution strobes
    input  logic                   i_commit_valid,
    input  ckpt_pkg::fgr_t         i_commit_fgr,
    input  logic                   i_abandon_valid,
    input  ckpt_pkg::fgr_t         i_abandon_fgr,

    // Bank side
    input  ckpt_pkg::bank_status_t i_status [`CKPT_BANK_COUNT],
    output ckpt_pkg::bank_cmd_t    o_cmd [`CKPT_BANK_COUNT],
    output logic                   o_acquire_ready
);
    import ckpt_pkg::*;

    bank_mask_t active;
    bank_mask_t idle;
    bank_mask_t acq_match;
    bank_mask_t commit_match;
    bank_mask_t abandon_match;
    bank_mask_t not_full;

    // Banks allowed to take this PRF, then the single winner
    bank_mask_t candidate;
    bank_mask_t write_sel;
    logic       carry;

    always_comb begin
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            active[i]        = (i_status[i].state == BANK_ACTIVE);
            idle[i]          = (i_status[i].state == BANK_IDLE);
            not_full[i]      = ~i_status[i].full;
            acq_match[i]     = active[i] & (i_status[i].fgr == i_acquire.fgr);
            commit_match[i]  = active[i] & (i_status[i].fgr == i_commit_fgr);
            abandon_match[i] = active[i] & (i_status[i].fgr == i_abandon_fgr);
        end
    end

    // Existing group first, a full match stalls rather than opening a new bank
    always_comb begin
        if (|acq_match) begin
            candidate = acq_match & not_full;
        end else begin
            candidate = idle;
        end
    end

    // Lowest-index pick
    always_comb begin
        carry = 1'b0;
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            write_sel[i] = candidate[i] & ~carry;
            carry        = carry | candidate[i];
        end
    end

    assign o_acquire_ready = i_acquire_valid & (|candidate);

    always_comb begin
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            o_cmd[i].write   = i_acquire_valid & write_sel[i];
            o_cmd[i].commit  = i_commit_valid & commit_match[i];
            o_cmd[i].abandon = i_abandon_valid & abandon_match[i];
        end
    end

endmodule

//--- hw/ckpt_bank.sv
// One checkpoint bank, commands are pre-qualified by the allocation controller
// Head is only meaningful while the bank is not empty
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_bank (
    input  logic                   clk,
    input  logic                   i_rst,

    // Decoded command for this bank
    input  ckpt_pkg::bank_cmd_t    i_cmd,
    input  ckpt_pkg::acquire_t     i_acquire,

    // Drain side
    input  logic                   i_pop,
    output ckpt_pkg::bank_status_t o_status
);
    import ckpt_pkg::*;

    typedef logic [`CKPT_FIFO_PTR_WIDTH-1:0] ptr_t;
    typedef logic [`CKPT_FIFO_PTR_WIDTH:0]   count_t;

    bank_state_t state_q;
    bank_state_t state_d;
    fgr_t        fgr_q;

    // PRF storage
    prf_t        fifo_mem [`CKPT_FIFO_DEPTH];
    ptr_t        rd_ptr_q;
    ptr_t        wr_ptr_q;
    count_t      count_q;

    logic        fifo_push;
    logic        fifo_pop;
    logic        fifo_clear;
    logic        fifo_full;
    logic        fifo_empty;

    assign fifo_full  = (count_q == count_t'(`CKPT_FIFO_DEPTH));
    assign fifo_empty = (count_q == '0);

    // Controller never writes a full bank
    assign fifo_push  = i_cmd.write;
    assign fifo_pop   = i_pop & ~fifo_empty;

    // A commit also drops any PRF written in the same cycle
    assign fifo_clear = i_cmd.commit;

    // Commit and abandon only arrive while active
    always_comb begin
        state_d = state_q;
        if (i_cmd.commit) begin
            state_d = BANK_IDLE;
        end else if (i_cmd.abandon) begin
            state_d = BANK_ABANDONED;
        end else begin
            case (state_q)
                BANK_IDLE: begin
                    if (i_cmd.write) begin
                        state_d = BANK_ACTIVE;
                    end
                end
                BANK_ACTIVE: begin
                    state_d = BANK_ACTIVE;
                end
                BANK_ABANDONED: begin
                    // Drain finished, slot is free again
                    if (fifo_empty) begin
                        state_d = BANK_IDLE;
                    end
                end
                default: begin
                    state_d = BANK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q  <= BANK_IDLE;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            state_q <= state_d;
            if (fifo_clear) begin
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (fifo_push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (fifo_pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                count_q <= count_q + count_t'(fifo_push) - count_t'(fifo_pop);
            end
        end
    end

    // Tag is rewritten with the same value on later writes of the group
    always_ff @(posedge clk) begin
        if (i_cmd.write) begin
            fgr_q <= i_acquire.fgr;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_push) begin
            fifo_mem[wr_ptr_q] <= i_acquire.prf;
        end
    end

    always_comb begin
        o_status.state = state_q;
        o_status.fgr   = fgr_q;
        o_status.full  = fifo_full;
        o_status.empty = fifo_empty;
        o_status.head  = fifo_mem[rd_ptr_q];
    end

endmodule

//--- hw/ckpt_pkg.sv
// Types shared by the checkpoint store
// Widths come from ckpt_settings.svh
`include "ckpt_settings.svh"

package ckpt_pkg;

    typedef logic [`CKPT_PRF_WIDTH-1:0] prf_t;
    typedef logic [`CKPT_FGR_WIDTH-1:0] fgr_t;
    typedef logic [`CKPT_BANK_COUNT-1:0] bank_mask_t;

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_ACTIVE,
        BANK_ABANDONED
    } bank_state_t;

    typedef struct packed {
        fgr_t fgr;
        prf_t prf;
    } acquire_t;

    // Write may arrive together with commit or abandon of the same bank
    typedef struct packed {
        logic write;
        logic commit;
        logic abandon;
    } bank_cmd_t;

    typedef struct packed {
        bank_state_t state;
        fgr_t        fgr;
        logic        full;
        logic        empty;
        prf_t        head;
    } bank_status_t;

endpackage

//--- hw/ckpt_release_arbiter.sv
// Fixed-priority drain, lower bank index wins
// Release PRF is zero while nothing is granted
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_release_arbiter (
    input  ckpt_pkg::bank_status_t i_status [`CKPT_BANK_COUNT],

    // Release handshake
    input  logic                   i_release_ready,
    output logic                   o_release_valid,
    output ckpt_pkg::prf_t         o_release_prf,

    // Per-bank pop
    output ckpt_pkg::bank_mask_t   o_pop
);
    import ckpt_pkg::*;

    bank_mask_t draining;
    bank_mask_t grant;
    logic       carry;
    prf_t       merged_prf;

    always_comb begin
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            draining[i] = (i_status[i].state == BANK_ABANDONED) & ~i_status[i].empty;
        end
    end

    always_comb begin
        carry = 1'b0;
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            grant[i] = draining[i] & ~carry;
            carry    = carry | draining[i];
        end
    end

    // Masked heads OR together, only the granted one survives
    always_comb begin
        merged_prf = '0;
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            merged_prf = merged_prf | ({`CKPT_PRF_WIDTH{grant[i]}} & i_status[i].head);
        end
    end

    assign o_release_valid = |grant;
    assign o_release_prf   = merged_prf;
    assign o_pop           = grant & {`CKPT_BANK_COUNT{i_release_ready}};

endmodule

//--- hw/ckpt_settings.svh
// Widths and counts for the checkpoint store
// FIFO depth must equal 2**CKPT_FIFO_PTR_WIDTH, pointers wrap naturally
`ifndef CKPT_SETTINGS_SVH
`define CKPT_SETTINGS_SVH

// Physical register index
`define CKPT_PRF_WIDTH 6

// Speculative group tag
`define CKPT_FGR_WIDTH 4

// Banks and per-bank capacity
`define CKPT_BANK_COUNT 4
`define CKPT_FIFO_DEPTH 4
`define CKPT_FIFO_PTR_WIDTH 2

`endif

//--- hw/freelist_checkpoint.sv
// Free list checkpoint store, FGR-keyed, drains abandoned groups in acquire order
// Same-cycle commit and abandon of one FGR is undefined
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module freelist_checkpoint (
    input  logic               clk,
    input  logic               i_rst,

    // PRFs acquired by in-flight groups
    input  logic               i_acquire_valid,
    input  ckpt_pkg::acquire_t i_acquire,
    output logic               o_acquire_ready,

    // Group commit
    input  logic               i_commit_valid,
    input  ckpt_pkg::fgr_t     i_commit_fgr,

    // Group abandon
    input  logic               i_abandon_valid,
    input  ckpt_pkg::fgr_t     i_abandon_fgr,

    // PRFs handed back to the free list
    output logic               o_release_valid,
    output ckpt_pkg::prf_t     o_release_prf,
    input  logic               i_release_ready
);
    import ckpt_pkg::*;

    bank_cmd_t    bank_cmd    [`CKPT_BANK_COUNT];
    bank_status_t bank_status [`CKPT_BANK_COUNT];
    bank_mask_t   bank_pop;

    ckpt_alloc_ctrl ckpt_alloc_ctrl_i (
        .i_acquire_valid (i_acquire_valid),
        .i_acquire       (i_acquire),
        .i_commit_valid  (i_commit_valid),
        .i_commit_fgr    (i_commit_fgr),
        .i_abandon_valid (i_abandon_valid),
        .i_abandon_fgr   (i_abandon_fgr),
        .i_status        (bank_status),
        .o_cmd           (bank_cmd),
        .o_acquire_ready (o_acquire_ready)
    );

    // Identical banks, bank index sets drain priority
    for (genvar i = 0; i < `CKPT_BANK_COUNT; i++) begin : g_bank
        ckpt_bank ckpt_bank_i (
            .clk       (clk),
            .i_rst     (i_rst),
            .i_cmd     (bank_cmd[i]),
            .i_acquire (i_acquire),
            .i_pop     (bank_pop[i]),
            .o_status  (bank_status[i])
        );
    end

    ckpt_release_arbiter ckpt_release_arbiter_i (
        .i_status        (bank_status),
        .i_release_ready (i_release_ready),
        .o_release_valid (o_release_valid),
        .o_release_prf   (o_release_prf),
        .o_pop           (bank_pop)
    );

endmodule

//--- verif/freelist_checkpoint_tb.sv
// Self-checking testbench with a queue-based model of the checkpoint banks
// Stimulus never reuses a draining FGR or commits and abandons one FGR together
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module freelist_checkpoint_tb;
    import ckpt_pkg::*;

    typedef struct packed {
        logic acq_ready;
        logic rel_valid;
        prf_t rel_prf;
    } expect_t;

    localparam int RANDOM_CYCLES = 400;
    // Sum of per-test cycle budgets including resets
    localparam int CYCLE_BUDGET = 16 * 7 + 60 + 50 + 40 + 120 + (RANDOM_CYCLES + 10);

    logic     clk;
    logic     i_rst;
    logic     i_acquire_valid;
    acquire_t i_acquire;
    logic     o_acquire_ready;
    logic     i_commit_valid;
    fgr_t     i_commit_fgr;
    logic     i_abandon_valid;
    fgr_t     i_abandon_fgr;
    logic     o_release_valid;
    prf_t     o_release_prf;
    logic     i_release_ready;

    // Reference model state
    bank_state_t m_state [`CKPT_BANK_COUNT];
    fgr_t        m_tag   [`CKPT_BANK_COUNT];
    prf_t        m_q     [`CKPT_BANK_COUNT][$];

    event        step_done;
    expect_t     exp_now;
    logic        seen_acq_ok;
    logic        seen_rel_valid;
    prf_t        released_q [$];
    logic        hold_check_en;
    logic        prev_hold;
    prf_t        prev_prf;
    logic [31:0] lcg_state;
    int          error_count;
    int          test_errors_at_start;
    int          tests_passed;
    int          tests_failed;

    freelist_checkpoint freelist_checkpoint_i (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_acquire_valid (i_acquire_valid),
        .i_acquire       (i_acquire),
        .o_acquire_ready (o_acquire_ready),
        .i_commit_valid  (i_commit_valid),
        .i_commit_fgr    (i_commit_fgr),
        .i_abandon_valid (i_abandon_valid),
        .i_abandon_fgr   (i_abandon_fgr),
        .o_release_valid (o_release_valid),
        .o_release_prf   (o_release_prf),
        .i_release_ready (i_release_ready)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // A full matching bank stalls and no match takes the lowest idle bank
    function automatic int pick_bank(fgr_t fgr);
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            if (m_state[i] == BANK_ACTIVE && m_tag[i] == fgr) begin
                return (m_q[i].size() < `CKPT_FIFO_DEPTH) ? i : -1;
            end
        end
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            if (m_state[i] == BANK_IDLE) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int grant_bank();
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            if (m_state[i] == BANK_ABANDONED && m_q[i].size() > 0) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic expect_t model_expect(logic acq_v, fgr_t fgr);
        expect_t e;
        int      g;
        e = '0;
        e.acq_ready = acq_v && (pick_bank(fgr) >= 0);
        g = grant_bank();
        if (g >= 0) begin
            e.rel_valid = 1'b1;
            e.rel_prf   = m_q[g][0];
        end
        return e;
    endfunction

    function automatic logic fgr_draining(fgr_t fgr);
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            if (m_state[i] == BANK_ABANDONED && m_tag[i] == fgr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Advances the model by one clock edge using the pre-edge state
    task automatic model_step(logic acq_v, acquire_t acq, logic com_v, fgr_t cfgr,
                              logic ab_v, fgr_t afgr, logic rel_rdy);
        int   wb;
        int   g;
        logic was_empty;
        logic com_hit;
        logic ab_hit;
        wb = acq_v ? pick_bank(acq.fgr) : -1;
        g  = grant_bank();
        for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
            was_empty = (m_q[i].size() == 0);
            com_hit   = com_v && m_state[i] == BANK_ACTIVE && m_tag[i] == cfgr;
            ab_hit    = ab_v && m_state[i] == BANK_ACTIVE && m_tag[i] == afgr;
            if (i == wb) begin
                m_q[i].push_back(acq.prf);
                m_tag[i] = acq.fgr;
                if (m_state[i] == BANK_IDLE) begin
                    m_state[i] = BANK_ACTIVE;
                end
            end
            if (i == g && rel_rdy) begin
                m_q[i].delete(0);
            end
            if (com_hit) begin
                m_state[i] = BANK_IDLE;
                m_q[i].delete();
            end else if (ab_hit) begin
                m_state[i] = BANK_ABANDONED;
            end else if (m_state[i] == BANK_ABANDONED && was_empty) begin
                m_state[i] = BANK_IDLE;
            end
        end
    endtask

    task automatic check_value(logic [31:0] actual, logic [31:0] expected, string what);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // Compare outputs with the model at every edge and then advance it
    always @(posedge clk) begin : compare_proc
        if (i_rst) begin
            for (int i = 0; i < `CKPT_BANK_COUNT; i++) begin
                m_state[i] = BANK_IDLE;
                m_q[i].delete();
            end
            prev_hold = 1'b0;
        end else begin
            exp_now = model_expect(i_acquire_valid, i_acquire.fgr);
            check_value(o_acquire_ready, exp_now.acq_ready, "acquire ready");
            check_value(o_release_valid, exp_now.rel_valid, "release valid");
            if (exp_now.rel_valid) begin
                check_value(o_release_prf, exp_now.rel_prf, "release PRF");
            end
            if (hold_check_en && prev_hold) begin
                check_value(o_release_valid, 1'b1, "held release valid");
                check_value(o_release_prf, prev_prf, "held release PRF");
            end
            prev_hold      = o_release_valid && !i_release_ready;
            prev_prf       = o_release_prf;
            seen_acq_ok    = o_acquire_ready;
            seen_rel_valid = o_release_valid;
            if (o_release_valid && i_release_ready) begin
                released_q.push_back(o_release_prf);
            end
            model_step(i_acquire_valid, i_acquire, i_commit_valid, i_commit_fgr,
                       i_abandon_valid, i_abandon_fgr, i_release_ready);
        end
        -> step_done;
    end

    task automatic drive_cycle(logic acq_v, fgr_t afgr, prf_t prf, logic com_v, fgr_t cfgr,
                               logic ab_v, fgr_t bfgr, logic rel_rdy);
        i_acquire_valid <= acq_v;
        i_acquire.fgr   <= afgr;
        i_acquire.prf   <= prf;
        i_commit_valid  <= com_v;
        i_commit_fgr    <= cfgr;
        i_abandon_valid <= ab_v;
        i_abandon_fgr   <= bfgr;
        i_release_ready <= rel_rdy;
        @(step_done);
    endtask

    task automatic acquire(fgr_t fgr, prf_t prf, logic expect_ok);
        drive_cycle(1'b1, fgr, prf, 1'b0, '0, 1'b0, '0, 1'b1);
        check_value(seen_acq_ok, expect_ok, "acquire accepted");
    endtask

    task automatic run_reset();
        i_rst <= 1'b1;
        drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b1);
        repeat (4) @(step_done);
        i_rst <= 1'b0;
    endtask

    // Idle cycles until o_release_valid drops
    task automatic wait_drain(int max_cycles, logic random_ready);
        int          n;
        logic [31:0] r;
        n = 0;
        do begin
            r = lcg_next();
            drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, random_ready ? r[23] : 1'b1);
            n++;
        end while (seen_rel_valid && n < max_cycles);
        if (seen_rel_valid) begin
            error_count++;
            $display("Error at %0t ns: drain still running after %0d cycles", $time, n);
        end
    endtask

    task automatic check_released(prf_t want[$]);
        check_value(released_q.size(), want.size(), "released PRF count");
        for (int i = 0; i < want.size() && i < released_q.size(); i++) begin
            check_value(released_q[i], want[i], "released PRF in order");
        end
    endtask

    task automatic finish_test(string name);
        if (error_count == test_errors_at_start) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, error_count - test_errors_at_start);
        end
        test_errors_at_start = error_count;
    endtask

    task automatic test_commit();
        run_reset();
        for (int g = 0; g < 4; g++) begin
            for (int k = 0; k < 4; k++) begin
                acquire(fgr_t'(g * 3 + 1), prf_t'(lcg_next() >> 26), 1'b1);
            end
        end
        for (int g = 0; g < 4; g++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, fgr_t'(g * 3 + 1), 1'b0, '0, 1'b1);
        end
        repeat (3) begin
            drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b1);
            check_value(seen_rel_valid, 1'b0, "release after commit");
        end
        for (int g = 0; g < 4; g++) begin
            acquire(fgr_t'(g + 8), prf_t'(g), 1'b1);
        end
    endtask

    task automatic test_abandon_order();
        prf_t want[$];
        run_reset();
        acquire(4'd2, 6'd33, 1'b1);
        for (int k = 0; k < 3; k++) begin
            want.push_back(prf_t'(lcg_next() >> 26));
            acquire(4'd9, want[k], 1'b1);
        end
        released_q.delete();
        drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b1, 4'd9, 1'b1);
        wait_drain(20, 1'b0);
        check_released(want);
    endtask

    task automatic test_stalls();
        run_reset();
        for (int k = 0; k < 4; k++) begin
            acquire(4'd2, prf_t'(k + 1), 1'b1);
        end
        acquire(4'd2, 6'd5, 1'b0);
        acquire(4'd5, 6'd6, 1'b1);
        acquire(4'd6, 6'd7, 1'b1);
        acquire(4'd7, 6'd8, 1'b1);
        acquire(4'd11, 6'd9, 1'b0);
        drive_cycle(1'b0, '0, '0, 1'b1, 4'd6, 1'b0, '0, 1'b1);
        acquire(4'd11, 6'd9, 1'b1);
        acquire(4'd2, 6'd10, 1'b0);
    endtask

    task automatic test_backpressure();
        prf_t want[$];
        run_reset();
        for (int k = 0; k < 4; k++) begin
            want.push_back(prf_t'(lcg_next() >> 26));
            acquire(4'd3, want[$], 1'b1);
        end
        for (int k = 0; k < 3; k++) begin
            want.push_back(prf_t'(lcg_next() >> 26));
            acquire(4'd12, want[$], 1'b1);
        end
        released_q.delete();
        hold_check_en = 1'b1;
        drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b1, 4'd3, 1'b0);
        drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b1, 4'd12, 1'b0);
        wait_drain(100, 1'b1);
        hold_check_en = 1'b0;
        check_released(want);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic        acq_v;
        logic        com_v;
        logic        ab_v;
        run_reset();
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            r     = lcg_next();
            acq_v = (r[31:30] != 2'b00) && !fgr_draining(fgr_t'(r[29:27]));
            com_v = (r[26:25] == 2'b00);
            ab_v  = (r[21:20] == 2'b00) && !(com_v && r[24:22] == r[19:17]);
            drive_cycle(acq_v, fgr_t'(r[29:27]), prf_t'(r[16:11]), com_v, fgr_t'(r[24:22]),
                        ab_v, fgr_t'(r[19:17]), r[10] | r[9]);
        end
    endtask

    initial begin
        clk             = 1'b0;
        i_rst           = 1'b1;
        i_acquire_valid = 1'b0;
        i_acquire       = '0;
        i_commit_valid  = 1'b0;
        i_commit_fgr    = '0;
        i_abandon_valid = 1'b0;
        i_abandon_fgr   = '0;
        i_release_ready = 1'b1;
        hold_check_en   = 1'b0;
        lcg_state       = 32'h8daf_3aa4;
        error_count     = 0;
        test_errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;

        // Each pass leaves an abandoned PRF pending that the next reset must clear
        for (int f = 0; f < 16; f++) begin
            run_reset();
            acquire(fgr_t'(f), prf_t'(f), 1'b1);
            drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b1, fgr_t'(f), 1'b0);
        end
        run_reset();
        drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b1);
        check_value(seen_rel_valid, 1'b0, "release valid after reset");
        finish_test("reset state");
        test_commit();
        finish_test("commit discards");
        test_abandon_order();
        finish_test("abandon order");
        test_stalls();
        finish_test("stalls");
        test_backpressure();
        finish_test("back-pressure and priority");
        test_random();
        finish_test("random mix");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(CYCLE_BUDGET * 100 + 5000);
        $display("Error at %0t ns: watchdog expired before the tests finished", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/ckpt_pkg.sv
hw/ckpt_bank.sv
hw/ckpt_alloc_ctrl.sv
hw/ckpt_release_arbiter.sv
hw/freelist_checkpoint.sv
verif/freelist_checkpoint_tb.sv
